/* hw/mdb_pkg.sv */
package mdb_pkg;

	// A bus word carries a frame-start flag above one byte
	localparam int word_width = 9;
	localparam int byte_width = 8;
	localparam int node_width = 7;

	// Receive buffer geometry
	localparam int addr_width = 6;
	localparam int depth = 2 ** addr_width;
	localparam int count_width = addr_width + 1;

	// Frame filter states
	localparam int state_width = 2;
	localparam logic [state_width-1:0] st_idle = 2'd0;
	localparam logic [state_width-1:0] st_accept = 2'd1;
	localparam logic [state_width-1:0] st_discard = 2'd2;

	// A data word holds one payload byte of the current frame
	typedef struct packed {
		logic start;
		logic [byte_width-1:0] payload;
	} mdb_data_view_t;

	// An address word opens a frame for one node or for every node
	typedef struct packed {
		logic start;
		logic broadcast;
		logic [node_width-1:0] node;
	} mdb_addr_view_t;

	// The same nine bits, read as whichever view the start flag selects
	typedef union packed {
		mdb_data_view_t as_data;
		mdb_addr_view_t as_addr;
	} mdb_word_t;

endpackage

/* hw/mem_data.sv */
module mem_data
	import mdb_pkg::*;
(
	input logic clock,
	input logic reset,

	input logic wr_en,
	input logic [word_width-1:0] data_in,

	input logic [addr_width-1:0] wr_ptr,
	input logic [addr_width-1:0] rd_ptr,

	output logic [word_width-1:0] data_out
);

	logic [word_width-1:0] mem [depth];

	// Only words the controller accepts are written, so a full buffer keeps its head
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			for (int i = 0; i < depth; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (wr_en)
		begin
			mem[wr_ptr] <= data_in;
		end
	end

	// The entry at the read pointer is registered on every edge
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			data_out <= '0;
		end
		else
		begin
			data_out <= mem[rd_ptr];
		end
	end

endmodule

/* hw/fifo_ctrl.sv */
module fifo_ctrl
	import mdb_pkg::*;
(
	input logic clock,
	input logic reset,

	input logic push,
	input logic pop,

	output logic wr_en,
	output logic [addr_width-1:0] wr_ptr,
	output logic [addr_width-1:0] rd_ptr,

	output logic [count_width-1:0] count,
	output logic empty,
	output logic full,

	output logic rd_valid,
	output logic dropped
);

	logic push_ok;
	logic pop_ok;
	logic [count_width-1:0] count_next;

	// A pop on an empty buffer does nothing, even if a push arrives with it
	assign pop_ok = pop & ~empty;

	// A full buffer still takes a word when a pop frees the head in the same cycle
	assign push_ok = push & (~full | pop);

	assign wr_en = push_ok;

	always_comb
	begin
		case ({push_ok, pop_ok})
			2'b10: count_next = count + 1'b1;
			2'b01: count_next = count - 1'b1;
			default: count_next = count;
		endcase
	end

	// Both pointers wrap past the last entry on their own
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			count <= '0;
			empty <= 1'b1;
			full <= 1'b0;
		end
		else
		begin
			count <= count_next;
			empty <= (count_next == '0);
			full <= (count_next == count_width'(depth));
		end
	end

	// The read data is in the memory's output register one cycle after the pop
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			rd_valid <= 1'b0;
			dropped <= 1'b0;
		end
		else
		begin
			rd_valid <= pop_ok;
			dropped <= push & ~push_ok;
		end
	end

	a_count_range: assert property (@(posedge clock) disable iff (!reset)
		count <= count_width'(depth));

	a_flags_exclusive: assert property (@(posedge clock) disable iff (!reset)
		!(empty && full));

endmodule

/* hw/frame_filter.sv */
module frame_filter
	import mdb_pkg::*;
(
	input logic clock,
	input logic reset,

	input logic [node_width-1:0] own_id,

	input logic rx_valid,
	input mdb_word_t rx_word,

	output logic push,
	output logic [word_width-1:0] push_word
);

	logic [state_width-1:0] state;
	logic [state_width-1:0] state_next;
	logic is_addr;
	logic for_us;

	// The start flag sits in the same place in both views
	assign is_addr = rx_word.as_data.start;

	// Broadcast frames are kept whatever node number they carry
	assign for_us = rx_word.as_addr.broadcast | (rx_word.as_addr.node == own_id);

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			state <= st_idle;
		end
		else
		begin
			state <= state_next;
		end
	end

	// Any address word decides the fate of the frame it opens
	always_comb
	begin
		case (state)
			st_idle, st_accept, st_discard:
			begin
				state_next = state;
				if (rx_valid && is_addr)
				begin
					if (for_us)
						state_next = st_accept;
					else
						state_next = st_discard;
				end
			end
			default:
			begin
				state_next = st_idle;
			end
		endcase
	end

	// Data words are only stored inside a kept frame
	always_comb
	begin
		push = 1'b0;
		if (rx_valid)
		begin
			if (is_addr)
				push = for_us;
			else
				push = (state == st_accept);
		end
	end

	assign push_word = rx_word;

	a_push_needs_word: assert property (@(posedge clock) disable iff (!reset)
		push |-> rx_valid);

	// After a frame for another node, no data word is stored until the next address word
	a_discard_holds: assert property (@(posedge clock) disable iff (!reset)
		(rx_valid && is_addr && !for_us) |=> ((push -> is_addr) until (rx_valid && is_addr)));

endmodule

/* hw/mdb_rx_buffer.sv */
module mdb_rx_buffer
	import mdb_pkg::*;
(
	input logic clock,
	input logic reset,

	input logic [node_width-1:0] own_id,

	input logic rx_valid,
	input logic [word_width-1:0] rx_word,

	input logic pop,
	output logic rd_valid,
	output logic [word_width-1:0] rd_word,

	output logic empty,
	output logic full,
	output logic [count_width-1:0] count,
	output logic dropped
);

	logic push;
	logic [word_width-1:0] push_word;
	logic wr_en;
	logic [addr_width-1:0] wr_ptr;
	logic [addr_width-1:0] rd_ptr;

	frame_filter u_filter (
		.clock(clock),
		.reset(reset),
		.own_id(own_id),
		.rx_valid(rx_valid),
		.rx_word(rx_word),
		.push(push),
		.push_word(push_word)
	);

	fifo_ctrl u_ctrl (
		.clock(clock),
		.reset(reset),
		.push(push),
		.pop(pop),
		.wr_en(wr_en),
		.wr_ptr(wr_ptr),
		.rd_ptr(rd_ptr),
		.count(count),
		.empty(empty),
		.full(full),
		.rd_valid(rd_valid),
		.dropped(dropped)
	);

	// The memory output register is the read port seen by the reader
	mem_data u_mem (
		.clock(clock),
		.reset(reset),
		.wr_en(wr_en),
		.data_in(push_word),
		.wr_ptr(wr_ptr),
		.rd_ptr(rd_ptr),
		.data_out(rd_word)
	);

endmodule

/* sim/mdb_rx_tests.svh */
// Drives one cycle of inputs and returns just after the edge that samples them
task automatic apply_inputs(input logic valid, input logic [word_width-1:0] word,
	input logic pop_now);
	rx_valid = valid;
	rx_word = word;
	pop = pop_now;
	@(posedge clock);
	#1;
endtask

task automatic idle_cycles(input int n);
	repeat (n) apply_inputs(1'b0, '0, 1'b0);
endtask

function automatic logic [word_width-1:0] addr_word(input logic bcast,
	input logic [node_width-1:0] node);
	return {1'b1, bcast, node};
endfunction

function automatic logic [word_width-1:0] random_data_word();
	return {1'b0, 8'($urandom)};
endfunction

task automatic send_frame(input logic bcast, input logic [node_width-1:0] node,
	input int n_data);
	apply_inputs(1'b1, addr_word(bcast, node), 1'b0);
	repeat (n_data) apply_inputs(1'b1, random_data_word(), 1'b0);
endtask

// Pops until empty rises, counting the words that come back
task automatic drain_buffer(output int got);
	int n;
	n = 0;
	got = 0;
	while (!empty && n < depth + 2)
	begin
		apply_inputs(1'b0, '0, 1'b1);
		if (rd_valid)
			got++;
		n++;
	end
	check_true(empty, "buffer did not become empty while draining");
	idle_cycles(1);
endtask

task automatic test_reset_state();
	check_value("empty", 1, empty);
	check_value("full", 0, full);
	check_value("count", 0, count);
	check_value("rd_valid", 0, rd_valid);
	apply_inputs(1'b0, '0, 1'b1);
	check_value("rd_valid", 0, rd_valid);
	idle_cycles(2);
endtask

task automatic test_own_frame();
	int got;
	send_frame(1'b0, own_node, 5);
	idle_cycles(1);
	check_value("count", 6, count);
	drain_buffer(got);
	check_value("rd_valid count", 6, got);
endtask

task automatic test_filtering();
	int got;
	send_frame(1'b0, 7'h2a, 4);
	idle_cycles(1);
	check_value("count", 0, count);
	send_frame(1'b1, 7'h33, 3);
	idle_cycles(1);
	check_value("count", 4, count);
	drain_buffer(got);
	check_value("rd_valid count", 4, got);
endtask

task automatic test_orphan_and_cut();
	int got;
	// Only a reset returns the filter to idle
	reset_dut();
	apply_inputs(1'b1, random_data_word(), 1'b0);
	apply_inputs(1'b1, random_data_word(), 1'b0);
	idle_cycles(1);
	check_value("count", 0, count);
	send_frame(1'b0, own_node, 2);
	send_frame(1'b0, 7'h16, 3);
	idle_cycles(1);
	check_value("count", 3, count);
	drain_buffer(got);
	check_value("rd_valid count", 3, got);
endtask

task automatic test_fill_and_drop();
	int got;
	send_frame(1'b0, own_node, depth - 1);
	check_value("full", 1, full);
	check_value("count", depth, count);
	apply_inputs(1'b1, random_data_word(), 1'b0);
	check_value("dropped", 1, dropped);
	check_value("count", depth, count);
	idle_cycles(1);
	check_value("dropped", 0, dropped);
	drain_buffer(got);
	check_value("rd_valid count", depth, got);
	check_value("empty", 1, empty);
endtask

task automatic test_wrap_stream();
	int got;
	send_frame(1'b0, own_node, 3);
	for (int i = 0; i < 80; i++)
	begin
		apply_inputs(1'b1, random_data_word(), 1'b1);
		check_value("count", 4, count);
	end
	idle_cycles(1);
	drain_buffer(got);
	check_value("rd_valid count", 4, got);
endtask

/* sim/tb_mdb_rx_buffer.sv */
module tb_mdb_rx_buffer
	import mdb_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [node_width-1:0] own_node = 7'h15;

	// Rough transfer counts per test, pushes and pops together
	localparam int transfers_reset = 2;
	localparam int transfers_own = 12;
	localparam int transfers_filter = 14;
	localparam int transfers_cut = 16;
	localparam int transfers_fill = 130;
	localparam int transfers_wrap = 170;
	localparam int total_transfers = transfers_reset + transfers_own + transfers_filter
		+ transfers_cut + transfers_fill + transfers_wrap;
	localparam int watchdog_ns = 200 * total_transfers + 2000;

	logic clock;
	logic reset;
	logic rx_valid;
	logic [word_width-1:0] rx_word;
	logic pop;
	logic rd_valid;
	logic [word_width-1:0] rd_word;
	logic empty;
	logic full;
	logic [count_width-1:0] count;
	logic dropped;

	int mismatches = 0;
	int other_failures = 0;

	// Reference model of the filter and the buffer contents
	logic [word_width-1:0] expected_q[$];
	logic model_accept = 1'b0;
	logic exp_rd_valid = 1'b0;
	logic exp_dropped = 1'b0;
	logic [word_width-1:0] exp_rd_word = '0;
	mdb_word_t seen;
	logic keep;
	logic take_push;
	logic take_pop;

	mdb_rx_buffer DUT (
		.clock(clock),
		.reset(reset),
		.own_id(own_node),
		.rx_valid(rx_valid),
		.rx_word(rx_word),
		.pop(pop),
		.rd_valid(rd_valid),
		.rd_word(rd_word),
		.empty(empty),
		.full(full),
		.count(count),
		.dropped(dropped)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic check_value(input string name, input int unsigned expected,
		input int unsigned actual);
		assert (actual == expected)
		else
		begin
			mismatches++;
			$display("FAILED at %0.1f ns: %s expected 'h%0h, actual 'h%0h",
				$realtime, name, expected, actual);
		end
	endtask

	task automatic check_true(input logic condition, input string what);
		assert (condition)
		else
		begin
			other_failures++;
			$display("Error at %0.1f ns: %s", $realtime, what);
		end
	endtask

	// Holds reset for five edges and releases it just after an edge
	task automatic reset_dut();
		rx_valid = 1'b0;
		rx_word = '0;
		pop = 1'b0;
		reset = 1'b0;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b1;
	endtask

	`include "mdb_rx_tests.svh"

	always @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			model_accept = 1'b0;
			expected_q.delete();
			exp_rd_valid = 1'b0;
			exp_dropped = 1'b0;
		end
		else
		begin
			seen = rx_word;
			keep = 1'b0;
			if (rx_valid && seen.as_addr.start)
			begin
				keep = seen.as_addr.broadcast || (seen.as_addr.node == own_node);
				model_accept = keep;
			end
			else if (rx_valid)
				keep = model_accept;
			take_pop = pop && (expected_q.size() > 0);
			take_push = keep && ((expected_q.size() < depth) || pop);
			exp_rd_valid = take_pop;
			exp_dropped = keep && !take_push;
			if (take_pop)
				exp_rd_word = expected_q.pop_front();
			if (take_push)
				expected_q.push_back(rx_word);
		end
	end

	// Outputs are compared half a cycle after the edge that moved them
	always @(negedge clock)
	begin
		if (reset)
		begin
			check_value("count", expected_q.size(), count);
			check_value("empty", expected_q.size() == 0, empty);
			check_value("full", expected_q.size() == depth, full);
			check_value("rd_valid", exp_rd_valid, rd_valid);
			check_value("dropped", exp_dropped, dropped);
			if (exp_rd_valid)
				check_value("rd_word", exp_rd_word, rd_word);
		end
	end

	initial
	begin
		#(watchdog_ns * 1ns);
		$display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
		$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		void'($urandom(32'hd933c3e5));
		reset_dut();
		test_reset_state();
		test_own_frame();
		test_filtering();
		test_orphan_and_cut();
		test_fill_and_drop();
		test_wrap_stream();
		$display("Errors: %0d value mismatches, %0d other failures",
			mismatches, other_failures);
		if (mismatches == 0 && other_failures == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* mdb_rx_buffer.f */
+incdir+sim
hw/mdb_pkg.sv
hw/mem_data.sv
hw/fifo_ctrl.sv
hw/frame_filter.sv
hw/mdb_rx_buffer.sv
sim/tb_mdb_rx_buffer.sv

/* Bender.yml */
package:
  name: mdb_rx_buffer

sources:
  - hw/mdb_pkg.sv
  - hw/mem_data.sv
  - hw/fifo_ctrl.sv
  - hw/frame_filter.sv
  - hw/mdb_rx_buffer.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mdb_rx_buffer.sv
